//--- logic/rv_pkg.sv
package rv_pkg;

  // datapath widths
  localparam int XLEN       = 32;
  localparam int REG_COUNT  = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  localparam word_t RESET_PC   = 32'h0000_0000;
  localparam word_t INSN_BYTES = 32'd4;  // pc step per instruction

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b00_000_11,  // decoded, not executed
    OP_MISC_MEM = 7'b00_011_11,
    OP_REG_IMM  = 7'b00_100_11,
    OP_AUIPC    = 7'b00_101_11,
    OP_STORE    = 7'b01_000_11,  // decoded, not executed
    OP_REG_REG  = 7'b01_100_11,
    OP_LUI      = 7'b01_101_11,
    OP_BRANCH   = 7'b11_000_11,
    OP_JALR     = 7'b11_001_11,
    OP_JAL      = 7'b11_011_11,
    OP_SYSTEM   = 7'b11_100_11
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  // same codes as branch funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_e;

endpackage

//--- logic/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  input  logic          branch_taken,
  input  logic          jump_en,
  input  rv_pkg::word_t jump_target,
  input  rv_pkg::word_t branch_target,
  input  logic          ecall,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4,
  output logic          halt
);

  logic          halted;   // sticky after ecall
  rv_pkg::word_t pc_next;

  assign halt     = ecall | halted;  // already high in the ecall cycle
  assign pc_plus4 = pc + rv_pkg::INSN_BYTES;  // also the link address

  always_comb begin
    if (halt) begin
      pc_next = pc;  // freeze on the ecall
    end else if (branch_taken) begin
      pc_next = branch_target;
    end else if (jump_en) begin
      pc_next = jump_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= rv_pkg::RESET_PC;
      halted <= 1'b0;
    end else begin
      pc <= pc_next;
      if (ecall) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

//--- logic/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::word_t        insn,
  input  rv_pkg::word_t        pc,
  input  rv_pkg::word_t        rs1_data,
  output rv_pkg::reg_addr_t    rs1,
  output rv_pkg::reg_addr_t    rs2,
  output rv_pkg::reg_addr_t    rd,
  output rv_pkg::word_t        imm,
  output rv_pkg::alu_op_e      alu_op,
  output logic                 alu_src_imm,
  output logic                 alu_src_pc,
  output logic                 wb_req,
  output logic                 wb_link,
  output logic                 is_branch,
  output rv_pkg::branch_cond_e branch_cond,
  output rv_pkg::word_t        branch_target,
  output logic                 jump_en,
  output rv_pkg::word_t        jump_target,
  output logic                 ecall
);

  logic [6:0]      funct7;
  logic [2:0]      funct3;
  rv_pkg::opcode_e opcode;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_j;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   jump_sum;
  logic            is_jal;
  logic            is_jalr;
  logic            alt_ok;   // funct7 = 0100000 allowed here
  logic            rr_ok;

  // funct3 to alu op, alt picks sub / sra
  function automatic rv_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_of = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  alu_of = rv_pkg::ALU_SLL;
      3'b010:  alu_of = rv_pkg::ALU_SLT;
      3'b011:  alu_of = rv_pkg::ALU_SLTU;
      3'b100:  alu_of = rv_pkg::ALU_XOR;
      3'b101:  alu_of = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  alu_of = rv_pkg::ALU_OR;
      default: alu_of = rv_pkg::ALU_AND;
    endcase
  endfunction

  assign funct7 = insn[31:25];
  assign funct3 = insn[14:12];
  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign rd     = insn[11:7];

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign alt_ok = (funct7 == 7'b0100000) && (funct3 == 3'b101 || opcode == rv_pkg::OP_REG_REG)
                  && (funct3 == 3'b000 || funct3 == 3'b101);
  assign rr_ok  = (funct7 == 7'b0000000) || alt_ok;

  always_comb begin
    imm         = imm_i;
    alu_op      = rv_pkg::ALU_ADD;
    alu_src_imm = 1'b0;
    alu_src_pc  = 1'b0;
    wb_req      = 1'b0;
    wb_link     = 1'b0;
    is_branch   = 1'b0;
    branch_cond = rv_pkg::BR_EQ;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    ecall       = 1'b0;
    case (opcode)
      rv_pkg::OP_LUI: begin
        imm         = imm_u;
        alu_op      = rv_pkg::ALU_PASS_B;
        alu_src_imm = 1'b1;
        wb_req      = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        imm         = imm_u;
        alu_src_imm = 1'b1;
        alu_src_pc  = 1'b1;
        wb_req      = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        imm     = imm_j;
        is_jal  = 1'b1;
        wb_req  = 1'b1;
        wb_link = 1'b1;
      end
      rv_pkg::OP_JALR: begin
        is_jalr = (funct3 == 3'b000);
        wb_req  = is_jalr;
        wb_link = 1'b1;
      end
      rv_pkg::OP_BRANCH: begin
        imm = imm_b;
        if (funct3[2:1] != 2'b01) begin  // 010 and 011 are not branches
          is_branch   = 1'b1;
          branch_cond = rv_pkg::branch_cond_e'(funct3);
        end
      end
      rv_pkg::OP_REG_IMM: begin
        alu_src_imm = 1'b1;
        alu_op      = alu_of(funct3, funct3 == 3'b101 && insn[30]);
        // shift immediates need a clean funct7
        wb_req      = (funct3[1:0] != 2'b01) || rr_ok;
      end
      rv_pkg::OP_REG_REG: begin
        alu_op = alu_of(funct3, insn[30]);
        wb_req = rr_ok;  // m-extension falls out here
      end
      rv_pkg::OP_MISC_MEM: begin
        // fence, nothing to do
      end
      rv_pkg::OP_SYSTEM: begin
        ecall = (insn[31:7] == 25'd0);
      end
      default: begin
        // loads, stores, anything else
      end
    endcase
  end

  assign branch_target = pc + imm_b;
  assign jump_en       = is_jal | is_jalr;
  assign jump_sum      = (is_jalr ? rs1_data : pc) + imm;
  assign jump_target   = {jump_sum[rv_pkg::XLEN-1:1], jump_sum[0] & ~is_jalr};  // jalr drops bit 0

endmodule

//--- logic/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data
);

  rv_pkg::word_t regs [1:rv_pkg::REG_COUNT-1];  // no storage for x0

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- logic/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_e      op,
  input  rv_pkg::word_t        a,
  input  rv_pkg::word_t        b,
  output rv_pkg::word_t        result,
  input  rv_pkg::branch_cond_e cond,
  input  rv_pkg::word_t        cmp_a,
  input  rv_pkg::word_t        cmp_b,
  output logic                 taken
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       br_lt_s;
  logic       br_lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:    result = a + b;
      rv_pkg::ALU_SUB:    result = a - b;
      rv_pkg::ALU_SLL:    result = a << shamt;
      rv_pkg::ALU_SLT:    result = {31'b0, lt_s};
      rv_pkg::ALU_SLTU:   result = {31'b0, lt_u};
      rv_pkg::ALU_XOR:    result = a ^ b;
      rv_pkg::ALU_SRL:    result = a >> shamt;
      rv_pkg::ALU_SRA:    result = $signed(a) >>> shamt;  // keeps the sign
      rv_pkg::ALU_OR:     result = a | b;
      rv_pkg::ALU_AND:    result = a & b;
      rv_pkg::ALU_PASS_B: result = b;
      default:            result = a + b;
    endcase
  end

  // branch compare on the raw register values
  assign br_lt_s = $signed(cmp_a) < $signed(cmp_b);
  assign br_lt_u = cmp_a < cmp_b;

  always_comb begin
    case (cond)
      rv_pkg::BR_EQ:  taken = (cmp_a == cmp_b);
      rv_pkg::BR_NE:  taken = (cmp_a != cmp_b);
      rv_pkg::BR_LT:  taken = br_lt_s;
      rv_pkg::BR_GE:  taken = ~br_lt_s;
      rv_pkg::BR_LTU: taken = br_lt_u;
      rv_pkg::BR_GEU: taken = ~br_lt_u;
      default:        taken = 1'b0;
    endcase
  end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     insn,
  output rv_pkg::word_t     pc,
  output logic              halt,
  output logic              wb_en,
  output rv_pkg::reg_addr_t wb_rd,
  output rv_pkg::word_t     wb_data
);

  rv_pkg::reg_addr_t    rs1, rs2, rd;
  rv_pkg::word_t        rs1_data, rs2_data, imm;
  rv_pkg::word_t        pc_plus4, alu_a, alu_b, alu_result;
  rv_pkg::word_t        branch_target, jump_target;
  rv_pkg::alu_op_e      alu_op;
  rv_pkg::branch_cond_e branch_cond;
  logic                 alu_src_imm, alu_src_pc;
  logic                 wb_req, wb_link, is_branch, taken, jump_en, ecall;

  rv_fetch fetch_i (
    .clk(clk), .rst(rst),
    .branch_taken(is_branch & taken),  // only real branches redirect
    .jump_en(jump_en), .jump_target(jump_target), .branch_target(branch_target),
    .ecall(ecall), .pc(pc), .pc_plus4(pc_plus4), .halt(halt)
  );

  rv_decode decode_i (
    .insn(insn), .pc(pc), .rs1_data(rs1_data),
    .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .alu_src_imm(alu_src_imm), .alu_src_pc(alu_src_pc),
    .wb_req(wb_req), .wb_link(wb_link), .is_branch(is_branch), .branch_cond(branch_cond),
    .branch_target(branch_target), .jump_en(jump_en), .jump_target(jump_target),
    .ecall(ecall)
  );

  rv_regfile regfile_i (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(wb_en), .rd(rd), .rd_data(wb_data)
  );

  assign alu_a = alu_src_pc ? pc : rs1_data;   // auipc uses pc
  assign alu_b = alu_src_imm ? imm : rs2_data;

  rv_alu alu_i (
    .op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result),
    .cond(branch_cond), .cmp_a(rs1_data), .cmp_b(rs2_data), .taken(taken)
  );

  // writeback trace, same wires that feed the register file
  assign wb_en   = wb_req & ~halt & ~rst;
  assign wb_rd   = rd;
  assign wb_data = wb_link ? pc_plus4 : alu_result;  // link address for jal/jalr

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 2;  // 4 ns clock

  initial clk = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

rv_pkg::word_t model_pc;
rv_pkg::word_t model_regs [32];
logic          model_halted;
logic [31:0]   lcg_state;

function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// r-type field order also serves branches with a fixed +8 offset
function automatic rv_pkg::word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, rv_pkg::opcode_e op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic rv_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, rv_pkg::opcode_e op);
  return {imm, rs1, f3, rd, op};
endfunction

task automatic emit(rv_pkg::word_t w);
  imem[prog_len] = w;
  prog_len++;
endtask

function automatic rv_pkg::word_t ref_alu(logic [2:0] f3, logic alt, rv_pkg::word_t a,
                                          rv_pkg::word_t b);
  logic signed [31:0] sa;
  sa = $signed(a) >>> b[4:0];
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? $unsigned(sa) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic ref_taken(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;  // 010 and 011 never branch
  endcase
endfunction

task automatic model_reset();
  model_pc     = rv_pkg::RESET_PC;
  model_halted = 1'b0;
  foreach (model_regs[i])
    model_regs[i] = '0;
endtask

// executes one instruction at model_pc and returns what the trace should show
task automatic model_step(input rv_pkg::word_t insn, output logic we,
                          output rv_pkg::word_t data, output logic halt_exp);
  rv_pkg::word_t a;
  rv_pkg::word_t b;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t next_pc;
  logic [2:0]    f3;
  logic [6:0]    f7;
  logic          ecall;
  a        = model_regs[insn[19:15]];
  b        = model_regs[insn[24:20]];
  imm_i    = {{20{insn[31]}}, insn[31:20]};
  f3       = insn[14:12];
  f7       = insn[31:25];
  next_pc  = model_pc + 32'd4;
  we       = 1'b0;
  data     = '0;
  ecall    = 1'b0;
  halt_exp = model_halted;
  if (!model_halted) begin
    case (insn[6:0])
      rv_pkg::OP_LUI: begin
        we   = 1'b1;
        data = {insn[31:12], 12'b0};
      end
      rv_pkg::OP_AUIPC: begin
        we   = 1'b1;
        data = model_pc + {insn[31:12], 12'b0};
      end
      rv_pkg::OP_JAL: begin
        we      = 1'b1;
        data    = model_pc + 32'd4;
        next_pc = model_pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      rv_pkg::OP_JALR: begin
        if (f3 == 3'b000) begin
          we      = 1'b1;
          data    = model_pc + 32'd4;
          next_pc = (a + imm_i) & ~32'd1;
        end
      end
      rv_pkg::OP_BRANCH: begin
        if (ref_taken(f3, a, b))
          next_pc = model_pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      end
      rv_pkg::OP_REG_IMM: begin
        we   = (f3 != 3'b001 && f3 != 3'b101) || f7 == 7'h00 || (f3 == 3'b101 && f7 == 7'h20);
        data = ref_alu(f3, f3 == 3'b101 && f7[5], a, imm_i);
      end
      rv_pkg::OP_REG_REG: begin
        we   = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        data = ref_alu(f3, f7[5], a, b);
      end
      rv_pkg::OP_SYSTEM: ecall = (insn[31:7] == 25'd0);
      default: ;  // fence, loads, stores, unknown
    endcase
    if (ecall)
      model_halted = 1'b1;  // pc holds from here on
    else
      model_pc = next_pc;
    if (we && insn[11:7] != 5'd0)
      model_regs[insn[11:7]] = data;
    halt_exp = ecall;
  end
endtask

task automatic build_program();
  logic [31:0]       r;
  logic [2:0]        f3;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  // unused words are loads tagged with their own index
  for (int i = 0; i < IMEM_WORDS; i++)
    imem[i] = (rv_pkg::word_t'(i) << 7) | 32'h0000_0003;
  prog_len = 0;
  emit(enc_i(12'h7ff, 5'd0, 3'b000, 5'd27, rv_pkg::OP_REG_IMM));  // asks for a write during reset too
  for (int i = 1; i < 16; i++) begin
    r = next_random();
    emit({r[31:12], rv_pkg::reg_addr_t'(i), rv_pkg::OP_LUI});
    emit(enc_i(r[11:0], rv_pkg::reg_addr_t'(i), 3'b000, rv_pkg::reg_addr_t'(i),
               rv_pkg::OP_REG_IMM));
  end
  emit({20'h12345, 5'd5, rv_pkg::OP_AUIPC});
  emit({20'h80000, 5'd6, rv_pkg::OP_LUI});  // negative value for signed compares
  for (int n = 0; n < 48; n++) begin
    r   = next_random();
    f3  = r[14:12];
    rs1 = {1'b0, r[18:15]};
    rs2 = {1'b0, r[23:20]};
    rd  = {1'b0, r[10:7]};  // x0 now and then
    if (r[31])
      emit(enc_r({1'b0, r[30] & (f3 == 3'b000 || f3 == 3'b101), 5'b0}, rs2, rs1, f3, rd,
                 rv_pkg::OP_REG_REG));
    else if (f3[1:0] == 2'b01)
      emit(enc_r({1'b0, r[30] & f3[2], 5'b0}, r[24:20], rs1, f3, rd, rv_pkg::OP_REG_IMM));
    else
      emit(enc_i(r[30:19], rs1, f3, rd, rv_pkg::OP_REG_IMM));
  end
  emit(enc_i(12'd5, 5'd0, 3'b000, 5'd20, rv_pkg::OP_REG_IMM));
  emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd21, rv_pkg::OP_REG_IMM));  // -3
  emit(enc_i(12'd5, 5'd0, 3'b000, 5'd22, rv_pkg::OP_REG_IMM));
  // pairs (x20,x21) (x21,x20) (x20,x22) give each condition a taken and an untaken case
  for (int c = 0; c < 8; c++) begin
    if (c == 2 || c == 3)
      continue;
    for (int k = 0; k < 3; k++) begin
      rs1 = (k == 1) ? 5'd21 : 5'd20;
      rs2 = (k == 0) ? 5'd21 : ((k == 1) ? 5'd20 : 5'd22);
      emit(enc_r(7'd0, rs2, rs1, 3'(c), 5'd8, rv_pkg::OP_BRANCH));  // +8
      emit(enc_i(12'd1, 5'd23, 3'b000, 5'd23, rv_pkg::OP_REG_IMM));
    end
  end
  emit({1'b0, 10'd6, 1'b0, 8'd0, 5'd1, rv_pkg::OP_JAL});  // jal x1, +12
  emit(enc_i(12'd1, 5'd23, 3'b000, 5'd23, rv_pkg::OP_REG_IMM));
  emit(enc_i(12'd1, 5'd23, 3'b000, 5'd23, rv_pkg::OP_REG_IMM));
  emit({20'h0, 5'd24, rv_pkg::OP_AUIPC});
  emit(enc_i(12'd13, 5'd24, 3'b000, 5'd25, rv_pkg::OP_JALR));  // odd target lands at +8
  emit(enc_i(12'd1, 5'd23, 3'b000, 5'd23, rv_pkg::OP_REG_IMM));
  emit(32'h0ff0_000f);
  emit(enc_i(12'd123, 5'd0, 3'b000, 5'd0, rv_pkg::OP_REG_IMM));
  emit(enc_r(7'd0, 5'd21, 5'd20, 3'b000, 5'd0, rv_pkg::OP_REG_REG));
  emit(enc_r(7'd0, 5'd20, 5'd0, 3'b000, 5'd26, rv_pkg::OP_REG_REG));  // reads x0
  emit(enc_i(12'd0, 5'd0, 3'b010, 5'd7, rv_pkg::OP_LOAD));  // unsupported
  emit(32'h0000_0073);  // ecall
endtask

`endif

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int          IMEM_WORDS   = 256;
  localparam int          RESET_CYCLES = 5;
  localparam int          HOLD_CYCLES  = 8;  // cycles watched after halt
  localparam logic [31:0] SEED         = 32'he8a6_7b0d;

  logic              clk;
  logic              rst;
  rv_pkg::word_t     insn;
  rv_pkg::word_t     pc;
  logic              halt;
  logic              wb_en;
  rv_pkg::reg_addr_t wb_rd;
  rv_pkg::word_t     wb_data;

  rv_pkg::word_t imem [IMEM_WORDS];
  int            prog_len;
  int            errors;
  logic          prog_ready;

  `include "rv_ref_model.svh"

  tb_clock_gen clk_gen_i (.clk(clk));

  rv_core dut_i (
    .clk(clk), .rst(rst), .insn(insn), .pc(pc), .halt(halt),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  assign insn = imem[pc[9:2]];  // word index is pc / 4

  task automatic report_mismatch(string name, rv_pkg::word_t expected, rv_pkg::word_t actual);
    $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
    errors++;
  endtask

  // sampled mid-cycle once outputs have settled
  task automatic check_cycle();
    logic              exp_we;
    logic              exp_halt;
    rv_pkg::word_t     exp_data;
    rv_pkg::reg_addr_t exp_rd;
    exp_rd = imem[model_pc[9:2]][11:7];
    assert (pc === model_pc) else report_mismatch("pc", model_pc, pc);
    model_step(imem[model_pc[9:2]], exp_we, exp_data, exp_halt);
    assert (halt === exp_halt) else report_mismatch("halt", {31'b0, exp_halt}, {31'b0, halt});
    assert (wb_en === exp_we) else report_mismatch("wb_en", {31'b0, exp_we}, {31'b0, wb_en});
    if (exp_we) begin
      assert (wb_rd === exp_rd) else report_mismatch("wb_rd", {27'b0, exp_rd}, {27'b0, wb_rd});
      assert (wb_data === exp_data) else report_mismatch("wb_data", exp_data, wb_data);
    end
  endtask

  initial begin
    int hold;
    rst        = 1'b1;
    errors     = 0;
    hold       = 0;
    prog_ready = 1'b0;
    lcg_state  = SEED;
    build_program();
    prog_ready = 1'b1;
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      @(negedge clk);
      assert (pc === rv_pkg::RESET_PC) else report_mismatch("pc", rv_pkg::RESET_PC, pc);
      assert (wb_en === 1'b0) else report_mismatch("wb_en", 32'd0, {31'b0, wb_en});
      assert (halt === 1'b0) else report_mismatch("halt", 32'd0, {31'b0, halt});
    end
    @(posedge clk);
    rst <= 1'b0;  // fifth edge with reset high
    model_reset();
    while (hold < HOLD_CYCLES) begin
      @(negedge clk);
      check_cycle();
      if (halt) begin
        hold++;
        if (hold == 1) begin
          @(posedge clk);
          // the ecall word becomes a write that the sticky halt has to mask
          imem[model_pc[9:2]] <= enc_i(12'h123, 5'd0, 3'b000, 5'd27, rv_pkg::OP_REG_IMM);
        end
      end
    end
    $display("program of %0d words done, %0d errors", prog_len, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // run limit grows with the program
  initial begin
    wait (prog_ready);
    repeat (4 * prog_len + 100) @(posedge clk);
    $display("timeout: core never halted within %0d cycles, %0d errors",
             4 * prog_len + 100, errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+verification
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_core.sv
verification/tb_clock_gen.sv
verification/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv_core_tb -f vlog.f &&
  ./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
